// ==== fb_quad_axi_master.f ====
+incdir+common
common/fb_pkg.sv
verilog/fb_frame_sync.sv
verilog/fb_sequencer.sv
fb_write/fb_write_master.sv
fb_read/fb_read_master.sv
verilog/fb_quad_axi_master.sv
verif/tb_clk_gen.sv
verif/tb_fb_quad_axi_master.sv

// ==== Bender.yml ====
package:
  name: fb_quad_axi_master

export_include_dirs:
  - common

sources:
  # design
  - include_dirs:
      - common
    files:
      - common/fb_pkg.sv
      - verilog/fb_frame_sync.sv
      - verilog/fb_sequencer.sv
      - fb_write/fb_write_master.sv
      - fb_read/fb_read_master.sv
      - verilog/fb_quad_axi_master.sv
  # testbench
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_fb_quad_axi_master.sv

// ==== verif/tb_fb_quad_axi_master.sv ====
// testbench top with DUT, AXI slave memory model, source FIFO models and reference checks
`default_nettype none

`include "fb_settings.svh"

module tb_fb_quad_axi_master;

    localparam int N_WR_OPS    = 40;
    localparam int N_RD_OPS    = 20;
    localparam int N_PRIO      = 8;
    localparam int OP_CYCLES   = 200;     // worst case for one operation at low ready rates
    localparam int N_OPS       = 4 + 2 * N_WR_OPS + N_RD_OPS + 2 * N_PRIO +
                                 2 * `FB_NUM_SRC + 1;
    localparam int CYCLE_LIMIT = (N_OPS + 5) * OP_CYCLES;

    wire                     M_AXI_ACLK;
    wire                     M_AXI_ARESETN;
    fb_pkg::src_sel_t        axi_wr_grant;
    fb_pkg::beat_t           video_wr_data [`FB_NUM_SRC];
    logic [`FB_NUM_SRC-1:0]  video_wr_en;
    logic [`FB_NUM_SRC-1:0]  video_frame_rst;
    logic                    rd_req;
    logic                    rd_frame_rst;
    logic                    rd_en;
    fb_pkg::beat_t           rd_data;
    fb_pkg::pix_addr_t       M_AXI_AWADDR;
    logic [3:0]              M_AXI_AWLEN;
    logic                    M_AXI_AWVALID;
    logic                    M_AXI_AWREADY;
    fb_pkg::beat_t           M_AXI_WDATA;
    logic                    M_AXI_WLAST;
    logic                    M_AXI_WREADY;
    fb_pkg::pix_addr_t       M_AXI_ARADDR;
    logic [3:0]              M_AXI_ARLEN;
    logic                    M_AXI_ARVALID;
    logic                    M_AXI_ARREADY;
    fb_pkg::beat_t           M_AXI_RDATA;
    logic                    M_AXI_RVALID;
    logic                    M_AXI_RLAST;

    // ******************************
    // reference model state
    // ******************************
    int unsigned        pops [`FB_NUM_SRC];       // pops seen per source FIFO
    fb_pkg::pix_addr_t  exp_qaddr [`FB_NUM_SRC];  // next expected quadrant address
    fb_pkg::pix_addr_t  exp_rd_addr = '0;
    fb_pkg::pix_addr_t  ar_q [$];                 // read bursts still owed data
    fb_pkg::pix_addr_t  first_aw;                 // first address of the last write
    fb_pkg::pix_addr_t  first_ar;
    fb_pkg::src_sel_t   wr_mask;
    int                 r_beat = 0;
    int                 aw_total = 0;
    int                 w_total = 0;
    int                 ar_total = 0;
    int                 op_aw = 0;
    int                 op_ar = 0;
    int                 op_beats = 0;
    int                 op_pops = 0;
    int                 op_rlast = 0;
    int                 wr_ops_done = 0;
    int                 rd_ops_done = 0;
    int                 cur_src = 0;
    int                 w_pct = 60;               // WREADY rate in percent
    logic               wr_active = 1'b0;
    logic               rd_active = 1'b0;
    int                 err_cnt = 0;
    int                 chk_cnt = 0;
    int                 cycle_cnt = 0;

    tb_clk_gen u_clk_gen (
        .clk   (M_AXI_ACLK),
        .rst_n (M_AXI_ARESETN)
    );

    fb_quad_axi_master u_fb_quad_axi_master (.*);

    // top left, top right, bottom left, bottom right
    function automatic fb_pkg::pix_addr_t quad_start(input int s);
        case (s)
            0:       return fb_pkg::pix_addr_t'(0);
            1:       return fb_pkg::pix_addr_t'(`FB_QUAD_H);
            2:       return fb_pkg::pix_addr_t'(`FB_DISP_H * `FB_QUAD_V);
            default: return fb_pkg::pix_addr_t'(`FB_QUAD_H + `FB_DISP_H * `FB_QUAD_V);
        endcase
    endfunction

    function automatic fb_pkg::beat_t fifo_head(input int s, input int unsigned k);
        return {16'(s), 48'(k)};
    endfunction

    // pixel address of the beat and its inverse
    function automatic fb_pkg::beat_t mem_word(input fb_pkg::pix_addr_t a, input int beat);
        fb_pkg::pix_addr_t pa;
        pa = a + fb_pkg::pix_addr_t'(beat * `FB_PIX_PER_BEAT);
        return {20'h5a5a5, pa, 20'h0, ~pa};
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        chk_cnt++;
        assert (got === exp)
        else
        begin
            $display("** Error @%0t: %s = %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        chk_cnt++;
        assert (cond)
        else
        begin
            $display("Failure @%0t: %s", $time, what);
            err_cnt++;
        end
    endtask

    // ******************************
    // AXI slave and monitors
    // ******************************
    always @(posedge M_AXI_ACLK)
    begin
        if (M_AXI_ARESETN)
        begin
            wr_mask = wr_active ? fb_pkg::src_sel_t'(1 << cur_src) : '0;
            compare_value("rd_en", rd_en, M_AXI_RVALID);
            compare_value("rd_data", rd_data, M_AXI_RDATA);
            if (M_AXI_AWVALID && M_AXI_AWREADY)
            begin
                expect_true(wr_active, "write address issued with no write granted");
                compare_value("M_AXI_AWADDR", M_AXI_AWADDR, exp_qaddr[cur_src]);
                compare_value("M_AXI_AWLEN", M_AXI_AWLEN, `FB_BURST_LEN - 1);
                if (op_aw == 0)
                    first_aw = M_AXI_AWADDR;
                op_aw++;
                aw_total++;
                exp_qaddr[cur_src] += `FB_BURST_STEP;
                if (op_aw == `FB_WR_BURSTS)         // skip the other quadrant's half line
                    exp_qaddr[cur_src] += `FB_DISP_H - `FB_QUAD_H;
            end
            if (M_AXI_WREADY)                       // only given inside a write
            begin
                compare_value("M_AXI_WDATA", M_AXI_WDATA, fifo_head(cur_src, pops[cur_src]));
                compare_value("M_AXI_WLAST", M_AXI_WLAST,
                              (op_beats % `FB_BURST_LEN) == `FB_BURST_LEN - 1);
                op_beats++;
                w_total++;
            end
            compare_value("video_wr_en", video_wr_en & ~wr_mask, '0);
            for (int s = 0; s < `FB_NUM_SRC; s++)
            begin
                if (video_wr_en[s])
                begin
                    pops[s]++;
                    video_wr_data[s] <= fifo_head(s, pops[s]);
                end
            end
            op_pops += $countones(video_wr_en & wr_mask);
            if (M_AXI_WREADY && op_beats == `FB_WR_BURSTS * `FB_BURST_LEN)
            begin
                expect_true(op_aw == `FB_WR_BURSTS,
                            $sformatf("write took %0d addresses", op_aw));
                expect_true(op_pops == `FB_WR_BURSTS * `FB_BURST_LEN,
                            $sformatf("write popped its source %0d times", op_pops));
                op_aw    = 0;
                op_beats = 0;
                op_pops  = 0;
                wr_ops_done++;
            end
            if (M_AXI_ARVALID && M_AXI_ARREADY)
            begin
                expect_true(rd_active, "read address issued with no read requested");
                compare_value("M_AXI_ARADDR", M_AXI_ARADDR, exp_rd_addr);
                compare_value("M_AXI_ARLEN", M_AXI_ARLEN, `FB_BURST_LEN - 1);
                if (op_ar == 0)
                    first_ar = M_AXI_ARADDR;
                op_ar++;
                ar_total++;
                exp_rd_addr += `FB_BURST_STEP;
                ar_q.push_back(M_AXI_ARADDR);
            end
            if (M_AXI_RVALID && M_AXI_RLAST)
            begin
                op_rlast++;
                if (op_rlast == `FB_RD_BURSTS)
                begin
                    expect_true(op_ar == `FB_RD_BURSTS,
                                $sformatf("read took %0d addresses", op_ar));
                    op_ar    = 0;
                    op_rlast = 0;
                    rd_ops_done++;
                end
            end
            // next cycle's ready and read data
            M_AXI_AWREADY <= ($urandom % 4) != 0;
            M_AXI_ARREADY <= ($urandom % 4) != 0;
            M_AXI_WREADY  <= (aw_total * `FB_BURST_LEN > w_total) && (($urandom % 100) < w_pct);
            if (ar_q.size() > 0 && ($urandom % 100) < 70)
            begin
                M_AXI_RVALID <= 1'b1;
                M_AXI_RDATA  <= mem_word(ar_q[0], r_beat);
                M_AXI_RLAST  <= (r_beat == `FB_BURST_LEN - 1);
                if (r_beat == `FB_BURST_LEN - 1)
                begin
                    r_beat = 0;
                    void'(ar_q.pop_front());
                end
                else
                    r_beat++;
            end
            else
            begin
                M_AXI_RVALID <= 1'b0;
                M_AXI_RLAST  <= 1'b0;
            end
        end
    end

    // ******************************
    // test sequences
    // ******************************
    task automatic run_op(input logic do_wr, input logic do_rd, input int s);
        int wr_target;
        int rd_target;
        int ar_before;
        wr_target = wr_ops_done + (do_wr ? 1 : 0);
        rd_target = rd_ops_done + (do_rd ? 1 : 0);
        @(posedge M_AXI_ACLK);
        if (exp_qaddr[s] == quad_start(s) + `FB_DISP_H * `FB_QUAD_V)   // quadrant complete
            exp_qaddr[s] = quad_start(s);
        if (exp_rd_addr == `FB_DISP_H * `FB_DISP_V)
            exp_rd_addr = '0;
        ar_before = ar_total;
        cur_src      <= s;
        wr_active    <= do_wr;
        rd_active    <= do_rd;
        axi_wr_grant <= do_wr ? fb_pkg::src_sel_t'(1 << s) : '0;
        rd_req       <= do_rd;
        wait (wr_ops_done == wr_target);
        axi_wr_grant <= '0;
        wr_active    <= 1'b0;
        if (do_wr && do_rd)     // write wins
            expect_true(ar_total == ar_before, "read address issued before the granted write");
        wait (rd_ops_done == rd_target);
        rd_req    <= 1'b0;
        rd_active <= 1'b0;
    endtask

    // s equal to FB_NUM_SRC selects the display side
    task automatic pulse_frame(input int s);
        @(posedge M_AXI_ACLK);
        if (s == `FB_NUM_SRC)
            rd_frame_rst <= 1'b1;
        else
            video_frame_rst[s] <= 1'b1;
        repeat (2) @(posedge M_AXI_ACLK);
        rd_frame_rst    <= 1'b0;
        video_frame_rst <= '0;
        repeat (6) @(posedge M_AXI_ACLK);   // sync, flag and rewind in idle
        if (s == `FB_NUM_SRC)
            exp_rd_addr = '0;
        else
            exp_qaddr[s] = quad_start(s);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %-26s %s", num, name, (err_cnt == errs_before) ? "passed" : "FAILED");
    endtask

    initial
    begin
        int e0;
        void'($urandom(32'hbe4c_892d));
        axi_wr_grant    = '0;
        video_frame_rst = '0;
        rd_req          = 1'b0;
        rd_frame_rst    = 1'b0;
        M_AXI_AWREADY   = 1'b0;
        M_AXI_WREADY    = 1'b0;
        M_AXI_ARREADY   = 1'b0;
        M_AXI_RVALID    = 1'b0;
        M_AXI_RLAST     = 1'b0;
        M_AXI_RDATA     = '0;
        for (int s = 0; s < `FB_NUM_SRC; s++)
        begin
            pops[s]          = 0;
            exp_qaddr[s]     = quad_start(s);
            video_wr_data[s] = fifo_head(s, 0);
        end
        wait (M_AXI_ARESETN);
        @(posedge M_AXI_ACLK);

        e0 = err_cnt;
        compare_value("M_AXI_AWVALID", M_AXI_AWVALID, 0);
        compare_value("M_AXI_ARVALID", M_AXI_ARVALID, 0);
        compare_value("M_AXI_WLAST", M_AXI_WLAST, 0);
        compare_value("video_wr_en", video_wr_en, 0);
        compare_value("rd_en", rd_en, 0);
        for (int s = 0; s < `FB_NUM_SRC; s++)
        begin
            run_op(1'b1, 1'b0, s);
            compare_value("M_AXI_AWADDR", first_aw, quad_start(s));
        end
        report_test(1, "reset and first writes", e0);

        e0 = err_cnt;
        repeat (N_WR_OPS) run_op(1'b1, 1'b0, $urandom_range(`FB_NUM_SRC - 1, 0));
        report_test(2, "write addresses", e0);

        e0 = err_cnt;
        w_pct = 30;             // heavy W back-pressure
        repeat (N_WR_OPS) run_op(1'b1, 1'b0, $urandom_range(`FB_NUM_SRC - 1, 0));
        w_pct = 60;
        report_test(3, "write data and pops", e0);

        e0 = err_cnt;
        repeat (N_RD_OPS) run_op(1'b0, 1'b1, 0);
        report_test(4, "read addresses and data", e0);

        e0 = err_cnt;
        repeat (N_PRIO) run_op(1'b1, 1'b1, $urandom_range(`FB_NUM_SRC - 1, 0));
        report_test(5, "write priority", e0);

        e0 = err_cnt;
        for (int s = 0; s < `FB_NUM_SRC; s++)
        begin
            // move off the quadrant start before the pulse
            if (exp_qaddr[s] == quad_start(s) ||
                exp_qaddr[s] == quad_start(s) + `FB_DISP_H * `FB_QUAD_V)
                run_op(1'b1, 1'b0, s);
            pulse_frame(s);
            run_op(1'b1, 1'b0, s);
            compare_value("M_AXI_AWADDR", first_aw, quad_start(s));
        end
        pulse_frame(`FB_NUM_SRC);
        run_op(1'b0, 1'b1, 0);
        compare_value("M_AXI_ARADDR", first_ar, 0);
        report_test(6, "frame-start rewind", e0);

        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // run limit
    initial
    begin
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge M_AXI_ACLK);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, an operation never finished", cycle_cnt);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
// testbench clock and reset generator
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // period 100
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);  // reset held for 4 cycles
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/fb_quad_axi_master.sv ====
// top level of the four-source frame writer and display-line reader
`default_nettype none

`include "fb_settings.svh"

module fb_quad_axi_master (
    input  wire                        M_AXI_ACLK,
    input  wire                        M_AXI_ARESETN,

    // write side
    input  fb_pkg::src_sel_t           axi_wr_grant,      // from external arbiter
    input  fb_pkg::beat_t              video_wr_data [`FB_NUM_SRC],
    output logic [`FB_NUM_SRC-1:0]     video_wr_en,
    input  wire  [`FB_NUM_SRC-1:0]     video_frame_rst,

    // read side
    input  wire                        rd_req,
    input  wire                        rd_frame_rst,
    output logic                       rd_en,
    output fb_pkg::beat_t              rd_data,

    // AXI master
    output fb_pkg::pix_addr_t          M_AXI_AWADDR,
    output logic [3:0]                 M_AXI_AWLEN,
    output logic                       M_AXI_AWVALID,
    input  wire                        M_AXI_AWREADY,
    output fb_pkg::beat_t              M_AXI_WDATA,
    output logic                       M_AXI_WLAST,
    input  wire                        M_AXI_WREADY,
    output fb_pkg::pix_addr_t          M_AXI_ARADDR,
    output logic [3:0]                 M_AXI_ARLEN,
    output logic                       M_AXI_ARVALID,
    input  wire                        M_AXI_ARREADY,
    input  fb_pkg::beat_t              M_AXI_RDATA,
    input  wire                        M_AXI_RVALID,
    input  wire                        M_AXI_RLAST
);

    fb_pkg::src_sel_t  wr_rewind;     // pending per-source rewinds
    fb_pkg::src_sel_t  wr_at_start;
    logic              rd_rewind;
    logic              rd_at_start;
    fb_pkg::fb_state_e state;
    fb_pkg::src_sel_t  src_sel;       // latched grant
    logic              wr_done;
    logic              rd_done;

    fb_frame_sync u_fb_frame_sync (
        .M_AXI_ACLK      (M_AXI_ACLK),
        .M_AXI_ARESETN   (M_AXI_ARESETN),
        .video_frame_rst (video_frame_rst),
        .rd_frame_rst    (rd_frame_rst),
        .wr_at_start     (wr_at_start),
        .rd_at_start     (rd_at_start),
        .wr_rewind       (wr_rewind),
        .rd_rewind       (rd_rewind)
    );

    fb_sequencer u_fb_sequencer (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .axi_wr_grant  (axi_wr_grant),
        .rd_req        (rd_req),
        .wr_rewind     (wr_rewind),
        .rd_rewind     (rd_rewind),
        .wr_done       (wr_done),
        .rd_done       (rd_done),
        .state         (state),
        .src_sel       (src_sel)
    );

    fb_write_master u_fb_write_master (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .state         (state),
        .src_sel       (src_sel),
        .axi_wr_grant  (axi_wr_grant),
        .wr_rewind     (wr_rewind),
        .video_wr_data (video_wr_data),
        .M_AXI_AWREADY (M_AXI_AWREADY),
        .M_AXI_WREADY  (M_AXI_WREADY),
        .video_wr_en   (video_wr_en),
        .wr_at_start   (wr_at_start),
        .wr_done       (wr_done),
        .M_AXI_AWADDR  (M_AXI_AWADDR),
        .M_AXI_AWLEN   (M_AXI_AWLEN),
        .M_AXI_AWVALID (M_AXI_AWVALID),
        .M_AXI_WDATA   (M_AXI_WDATA),
        .M_AXI_WLAST   (M_AXI_WLAST)
    );

    fb_read_master u_fb_read_master (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .state         (state),
        .rd_rewind     (rd_rewind),
        .M_AXI_ARREADY (M_AXI_ARREADY),
        .M_AXI_RVALID  (M_AXI_RVALID),
        .M_AXI_RDATA   (M_AXI_RDATA),
        .M_AXI_RLAST   (M_AXI_RLAST),
        .rd_at_start   (rd_at_start),
        .rd_done       (rd_done),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .M_AXI_ARADDR  (M_AXI_ARADDR),
        .M_AXI_ARLEN   (M_AXI_ARLEN),
        .M_AXI_ARVALID (M_AXI_ARVALID)
    );

endmodule

`default_nettype wire

// ==== fb_read/fb_read_master.sv ====
// linear read address generator, AR channel, R burst counting and output pass-through
`default_nettype none

`include "fb_settings.svh"

module fb_read_master (
    input  wire                 M_AXI_ACLK,
    input  wire                 M_AXI_ARESETN,
    input  fb_pkg::fb_state_e   state,
    input  wire                 rd_rewind,
    input  wire                 M_AXI_ARREADY,
    input  wire                 M_AXI_RVALID,
    input  fb_pkg::beat_t       M_AXI_RDATA,
    input  wire                 M_AXI_RLAST,
    output logic                rd_at_start,
    output logic                rd_done,
    output logic                rd_en,
    output fb_pkg::beat_t       rd_data,
    output fb_pkg::pix_addr_t   M_AXI_ARADDR,
    output logic [3:0]          M_AXI_ARLEN,
    output logic                M_AXI_ARVALID
);

    localparam fb_pkg::pix_addr_t frame_end = fb_pkg::pix_addr_t'(`FB_DISP_H * `FB_DISP_V);

    fb_pkg::pix_addr_t  rd_addr;
    fb_pkg::burst_cnt_t ar_cnt;       // addresses accepted
    fb_pkg::burst_cnt_t rb_cnt;       // bursts returned
    logic               rd_run;
    logic               ar_fire;
    logic               ar_last;

    assign rd_run  = (state == fb_pkg::ST_RD_RUN);
    assign ar_fire = M_AXI_ARVALID && M_AXI_ARREADY;
    assign ar_last = (ar_cnt == fb_pkg::burst_cnt_t'(`FB_RD_BURSTS - 1));

    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN)
    begin
        if (!M_AXI_ARESETN)
            rd_addr <= '0;
        else if (state == fb_pkg::ST_IDLE)
        begin
            if (rd_rewind || rd_addr == frame_end)   // new display frame
                rd_addr <= '0;
        end
        else if (rd_run && ar_fire)
            rd_addr <= rd_addr + fb_pkg::pix_addr_t'(`FB_BURST_STEP);
    end

    // ******************************
    // AR channel and R counting
    // ******************************
    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN)
    begin
        if (!M_AXI_ARESETN)
        begin
            M_AXI_ARVALID <= 1'b0;
            ar_cnt        <= '0;
            rb_cnt        <= '0;
        end
        else if (state == fb_pkg::ST_RD_START)
        begin
            M_AXI_ARVALID <= 1'b1;
            ar_cnt        <= '0;
            rb_cnt        <= '0;
        end
        else if (rd_run)
        begin
            if (ar_fire)
            begin
                ar_cnt <= ar_cnt + 1'b1;
                if (ar_last)
                    M_AXI_ARVALID <= 1'b0;
            end
            if (M_AXI_RVALID && M_AXI_RLAST)
                rb_cnt <= rb_cnt + 1'b1;
        end
        else
            M_AXI_ARVALID <= 1'b0;
    end

    assign M_AXI_ARADDR = rd_addr;
    assign M_AXI_ARLEN  = 4'(`FB_BURST_LEN - 1);
    assign rd_at_start  = (rd_addr == '0);
    assign rd_done      = rd_run && M_AXI_RVALID && M_AXI_RLAST &&
                          (rb_cnt == fb_pkg::burst_cnt_t'(`FB_RD_BURSTS - 1));

    // output FIFO always has room for read data
    assign rd_en   = M_AXI_RVALID;
    assign rd_data = M_AXI_RDATA;

    a_ar_hold : assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_ARVALID && !M_AXI_ARREADY |=> M_AXI_ARVALID && $stable(M_AXI_ARADDR));

endmodule

`default_nettype wire

// ==== fb_write/fb_write_master.sv ====
// quadrant write address generator, AW channel, W beat counting and source pops
`default_nettype none

`include "fb_settings.svh"

module fb_write_master (
    input  wire                      M_AXI_ACLK,
    input  wire                      M_AXI_ARESETN,
    input  fb_pkg::fb_state_e        state,
    input  fb_pkg::src_sel_t         src_sel,
    input  fb_pkg::src_sel_t         axi_wr_grant,
    input  fb_pkg::src_sel_t         wr_rewind,
    input  fb_pkg::beat_t            video_wr_data [`FB_NUM_SRC],
    input  wire                      M_AXI_AWREADY,
    input  wire                      M_AXI_WREADY,
    output logic [`FB_NUM_SRC-1:0]   video_wr_en,
    output fb_pkg::src_sel_t         wr_at_start,
    output logic                     wr_done,
    output fb_pkg::pix_addr_t        M_AXI_AWADDR,
    output logic [3:0]               M_AXI_AWLEN,
    output logic                     M_AXI_AWVALID,
    output fb_pkg::beat_t            M_AXI_WDATA,
    output logic                     M_AXI_WLAST
);

    fb_pkg::pix_addr_t  quad_addr [`FB_NUM_SRC];   // next burst address per quadrant
    fb_pkg::burst_cnt_t aw_cnt;                    // addresses accepted
    fb_pkg::burst_cnt_t beat_cnt;                  // beat within burst
    fb_pkg::burst_cnt_t wb_cnt;                    // bursts finished
    logic               aw_fire;
    logic               aw_last;
    logic               w_fire;
    logic               wr_run;

    assign wr_run  = (state == fb_pkg::ST_WR_RUN);
    assign aw_fire = M_AXI_AWVALID && M_AXI_AWREADY;
    assign aw_last = (aw_cnt == fb_pkg::burst_cnt_t'(`FB_WR_BURSTS - 1));
    assign w_fire  = wr_run && M_AXI_WREADY;

    // ******************************
    // quadrant address counters
    // ******************************
    for (genvar q = 0; q < `FB_NUM_SRC; q++)
    begin : g_quad
        // quadrant 0 top left, 1 top right, 2 bottom left, 3 bottom right
        localparam fb_pkg::pix_addr_t quad_start = fb_pkg::pix_addr_t'(
            (q % 2) * `FB_QUAD_H + (q / 2) * `FB_DISP_H * `FB_QUAD_V);
        localparam fb_pkg::pix_addr_t quad_end = fb_pkg::pix_addr_t'(
            quad_start + `FB_DISP_H * `FB_QUAD_V);

        always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN)
        begin
            if (!M_AXI_ARESETN)
                quad_addr[q] <= quad_start;
            else if (state == fb_pkg::ST_IDLE)
            begin
                if (wr_rewind[q] || quad_addr[q] == quad_end)
                    quad_addr[q] <= quad_start;
            end
            else if (wr_run && aw_fire && src_sel[q])
            begin
                if (aw_last)   // end of quadrant line, skip to next row
                    quad_addr[q] <= quad_addr[q] + fb_pkg::pix_addr_t'(
                        `FB_BURST_STEP + `FB_DISP_H - `FB_QUAD_H);
                else
                    quad_addr[q] <= quad_addr[q] + fb_pkg::pix_addr_t'(`FB_BURST_STEP);
            end
        end

        assign wr_at_start[q] = (quad_addr[q] == quad_start);
    end

    // ******************************
    // AW channel
    // ******************************
    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN)
    begin
        if (!M_AXI_ARESETN)
        begin
            M_AXI_AWVALID <= 1'b0;
            aw_cnt        <= '0;
        end
        else if (state == fb_pkg::ST_WR_START)
        begin
            M_AXI_AWVALID <= 1'b1;             // up in first run cycle
            aw_cnt        <= '0;
        end
        else if (wr_run)
        begin
            if (aw_fire)
            begin
                aw_cnt <= aw_cnt + 1'b1;
                if (aw_last)
                    M_AXI_AWVALID <= 1'b0;
            end
        end
        else
            M_AXI_AWVALID <= 1'b0;
    end

    assign M_AXI_AWLEN = 4'(`FB_BURST_LEN - 1);

    // address and data follow the latched source
    always_comb
    begin
        M_AXI_AWADDR = '0;
        M_AXI_WDATA  = '0;
        for (int i = 0; i < `FB_NUM_SRC; i++)
        begin
            if (src_sel[i])
            begin
                M_AXI_AWADDR = quad_addr[i];
                M_AXI_WDATA  = video_wr_data[i];
            end
        end
    end

    // ******************************
    // W channel
    // ******************************
    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN)
    begin
        if (!M_AXI_ARESETN)
        begin
            beat_cnt <= '0;
            wb_cnt   <= '0;
        end
        else if (state == fb_pkg::ST_WR_START)
        begin
            beat_cnt <= '0;
            wb_cnt   <= '0;
        end
        else if (w_fire)
        begin
            if (M_AXI_WLAST)
            begin
                beat_cnt <= '0;
                wb_cnt   <= wb_cnt + 1'b1;
            end
            else
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign M_AXI_WLAST = wr_run && (beat_cnt == fb_pkg::burst_cnt_t'(`FB_BURST_LEN - 1));
    assign wr_done     = w_fire && M_AXI_WLAST &&
                         (wb_cnt == fb_pkg::burst_cnt_t'(`FB_WR_BURSTS - 1));

    // one pop in the start state, then one per beat but not on the final one
    always_comb
    begin
        case (state)
            fb_pkg::ST_WR_START:
                video_wr_en = axi_wr_grant;
            fb_pkg::ST_WR_RUN:
                video_wr_en = (M_AXI_WREADY && !wr_done) ? src_sel : '0;
            default:
                video_wr_en = '0;
        endcase
    end

    a_wlast_src : assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_WLAST |-> wr_run && $onehot(src_sel));

endmodule

`default_nettype wire

// ==== verilog/fb_sequencer.sv ====
// idle/write/read state machine with write priority and granted-source latch
`default_nettype none

`include "fb_settings.svh"

module fb_sequencer (
    input  wire                 M_AXI_ACLK,
    input  wire                 M_AXI_ARESETN,
    input  fb_pkg::src_sel_t    axi_wr_grant,
    input  wire                 rd_req,
    input  fb_pkg::src_sel_t    wr_rewind,
    input  wire                 rd_rewind,
    input  wire                 wr_done,
    input  wire                 rd_done,
    output fb_pkg::fb_state_e   state,
    output fb_pkg::src_sel_t    src_sel
);

    fb_pkg::fb_state_e state_nxt;

    // ******************************
    // state machine
    // ******************************
    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN)
    begin
        if (!M_AXI_ARESETN)
            state <= fb_pkg::ST_IDLE;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            fb_pkg::ST_IDLE:
                if (|wr_rewind || rd_rewind)       // let the counters rewind first
                    state_nxt = fb_pkg::ST_IDLE;
                else if (|axi_wr_grant)            // writes win
                    state_nxt = fb_pkg::ST_WR_START;
                else if (rd_req)
                    state_nxt = fb_pkg::ST_RD_START;
            fb_pkg::ST_WR_START:
                state_nxt = fb_pkg::ST_WR_RUN;
            fb_pkg::ST_WR_RUN:
                if (wr_done)
                    state_nxt = fb_pkg::ST_IDLE;
            fb_pkg::ST_RD_START:
                state_nxt = fb_pkg::ST_RD_RUN;
            fb_pkg::ST_RD_RUN:
                if (rd_done)
                    state_nxt = fb_pkg::ST_IDLE;
            default:
                state_nxt = fb_pkg::ST_IDLE;
        endcase
    end

    // grant held for the whole operation
    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN)
    begin
        if (!M_AXI_ARESETN)
            src_sel <= '0;
        else if (state == fb_pkg::ST_WR_START)
            src_sel <= axi_wr_grant;
    end

    // ******************************
    // checks
    // ******************************
    a_grant_onehot : assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        $onehot0(axi_wr_grant));

    // a grant dropped before the latch leaves the write with no source
    a_grant_held : assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        state == fb_pkg::ST_WR_START |-> |axi_wr_grant);

endmodule

`default_nettype wire

// ==== verilog/fb_frame_sync.sv ====
// frame-start synchronizers, edge detect and pending-rewind flags
`default_nettype none

`include "fb_settings.svh"

module fb_frame_sync (
    input  wire                    M_AXI_ACLK,
    input  wire                    M_AXI_ARESETN,
    input  wire [`FB_NUM_SRC-1:0]  video_frame_rst,
    input  wire                    rd_frame_rst,
    input  fb_pkg::src_sel_t       wr_at_start,
    input  wire                    rd_at_start,
    output fb_pkg::src_sel_t       wr_rewind,
    output logic                   rd_rewind
);

    // bit FB_NUM_SRC is the display side, the rest are the sources
    logic [`FB_NUM_SRC:0] frame_in;
    logic [`FB_NUM_SRC:0] at_start;
    logic [`FB_NUM_SRC:0] sync_q0;    // first synchronizer stage
    logic [`FB_NUM_SRC:0] sync_q1;
    logic [`FB_NUM_SRC:0] prev_q;     // for edge detect
    logic [`FB_NUM_SRC:0] rewind_q;

    assign frame_in = {rd_frame_rst, video_frame_rst};
    assign at_start = {rd_at_start, wr_at_start};

    always_ff @(posedge M_AXI_ACLK or negedge M_AXI_ARESETN)
    begin
        if (!M_AXI_ARESETN)
        begin
            sync_q0  <= '0;
            sync_q1  <= '0;
            prev_q   <= '0;
            rewind_q <= '0;
        end
        else
        begin
            sync_q0  <= frame_in;
            sync_q1  <= sync_q0;
            prev_q   <= sync_q1;
            // a new edge wins over a clear in the same cycle
            rewind_q <= (rewind_q & ~at_start) | (sync_q1 & ~prev_q);
        end
    end

    assign wr_rewind = rewind_q[`FB_NUM_SRC-1:0];
    assign rd_rewind = rewind_q[`FB_NUM_SRC];

endmodule

`default_nettype wire

// ==== common/fb_pkg.sv ====
// vector typedefs and sequencer state enum for the frame buffer master
`default_nettype none

`include "fb_settings.svh"

package fb_pkg;

    // ******************************
    // vector types
    // ******************************
    typedef logic [`FB_ADDR_W-1:0]  pix_addr_t;   // linear pixel address
    typedef logic [`FB_DATA_W-1:0]  beat_t;       // one W or R beat
    typedef logic [`FB_NUM_SRC-1:0] src_sel_t;    // one bit per source, one-hot
    typedef logic [3:0]             burst_cnt_t;  // bursts or beats in one operation

    // ******************************
    // sequencer states
    // ******************************
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_WR_START = 3'd1,   // latch grant, prefetch first beat
        ST_WR_RUN   = 3'd2,
        ST_RD_START = 3'd3,
        ST_RD_RUN   = 3'd4
    } fb_state_e;

endpackage

`default_nettype wire

// ==== common/fb_settings.svh ====
// frame geometry, burst length and bus width macros for the frame buffer master
`ifndef FB_SETTINGS_SVH
`define FB_SETTINGS_SVH

// ******************************
// display and quadrant geometry
// ******************************
`define FB_DISP_H        64   // pixels per display line
`define FB_DISP_V        8    // display lines per frame
`define FB_QUAD_H        32   // pixels per quadrant line
`define FB_QUAD_V        4    // lines per quadrant

// ******************************
// bus and burst shape
// ******************************
`define FB_BURST_LEN     4    // beats per burst, both directions
`define FB_PIX_PER_BEAT  4
`define FB_DATA_W        64
`define FB_ADDR_W        12   // pixel address
`define FB_NUM_SRC       4

// derived values
`define FB_BURST_STEP    (`FB_BURST_LEN * `FB_PIX_PER_BEAT)
`define FB_WR_BURSTS     (`FB_QUAD_H / `FB_BURST_STEP)
`define FB_RD_BURSTS     (`FB_DISP_H / `FB_BURST_STEP)

`endif
